// File: router_defines.svh
`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

// router geometry
`define ROUTER_P 4   // ports
`define ROUTER_V 2   // virtual channels per port
`define ROUTER_LB 4  // flit slots per input vc

// field widths
`define ROUTER_PW 2  // port number
`define ROUTER_VW 1  // vc number
`define ROUTER_DW 16 // payload

// type + dest_port + payload
`define ROUTER_FW 20

// credit counter, holds 0 .. ROUTER_LB
`define ROUTER_CW 3

`endif

// File: router_pkg.sv
`include "router_defines.svh"

package router_pkg;

    typedef enum logic [1:0] {
        flit_head   = 2'd0,
        flit_body   = 2'd1,
        flit_tail   = 2'd2,
        flit_single = 2'd3 // head and tail in one flit
    } flit_type_e;

    // per input vc packet state
    typedef enum logic [1:0] {
        ivc_idle     = 2'd0,
        ivc_wait_ovc = 2'd1, // head waiting for its output vc
        ivc_active   = 2'd2
    } ivc_state_e;

    typedef logic [`ROUTER_PW-1:0] port_t;
    typedef logic [`ROUTER_DW-1:0] payload_t;

    // lookahead route, dest_port is the output port of this router
    typedef struct packed {
        flit_type_e ftype;
        port_t      dest_port;
        payload_t   payload;
    } flit_t;

endpackage

// File: input_port.sv
`include "router_defines.svh"

module input_port (
    input  logic                                  clk,
    input  logic                                  rst,
    input  router_pkg::flit_t                     flit_in,
    input  logic                                  flit_in_wr,
    input  logic [`ROUTER_VW-1:0]                 flit_in_vc,
    input  logic [`ROUTER_V-1:0]                  ivc_grant,
    output logic [`ROUTER_V-1:0]                  ivc_req,
    output logic [`ROUTER_V-1:0]                  ivc_is_head,
    output logic [`ROUTER_V-1:0]                  ivc_is_tail,
    output logic [`ROUTER_V-1:0][`ROUTER_PW-1:0]  ivc_dest,
    output router_pkg::flit_t [`ROUTER_V-1:0]     ivc_flit,
    output logic [`ROUTER_V-1:0]                  credit_out
);

    localparam int AW = $clog2(`ROUTER_LB);

    for (genvar v = 0; v < `ROUTER_V; v++) begin : g_vc
        router_pkg::flit_t          mem [`ROUTER_LB];
        router_pkg::flit_t          front;
        router_pkg::ivc_state_e     state;
        logic [AW-1:0]              wr_ptr;
        logic [AW-1:0]              rd_ptr;
        logic [`ROUTER_CW-1:0]      count;
        logic [`ROUTER_PW-1:0]      dest_q;
        logic                       push;
        logic                       pop;
        logic                       front_head;
        logic                       front_tail;

        assign push  = flit_in_wr && (flit_in_vc == `ROUTER_VW'(v));
        assign pop   = ivc_grant[v]; // allocator only grants a non-empty vc
        assign front = mem[rd_ptr];

        assign front_head = (front.ftype == router_pkg::flit_head) ||
                            (front.ftype == router_pkg::flit_single);
        assign front_tail = (front.ftype == router_pkg::flit_tail) ||
                            (front.ftype == router_pkg::flit_single);

        assign ivc_req[v]     = (count != '0);
        assign ivc_is_head[v] = front_head && (state != router_pkg::ivc_active);
        assign ivc_is_tail[v] = front_tail;
        // an idle vc routes straight from the head in front
        assign ivc_dest[v]    = (state == router_pkg::ivc_idle) ? front.dest_port : dest_q;
        assign ivc_flit[v]    = front;

        always_ff @(posedge clk) begin
            if (push) begin
                mem[wr_ptr] <= flit_in;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= (wr_ptr == AW'(`ROUTER_LB - 1)) ? '0 : wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= (rd_ptr == AW'(`ROUTER_LB - 1)) ? '0 : rd_ptr + 1'b1;
                end
                count <= count + `ROUTER_CW'(push) - `ROUTER_CW'(pop);
            end
        end

        // route of the current packet
        always_ff @(posedge clk) begin
            if (state == router_pkg::ivc_idle && ivc_req[v] && front_head) begin
                dest_q <= front.dest_port;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                state <= router_pkg::ivc_idle;
            end else begin
                case (state)
                    router_pkg::ivc_idle: begin
                        if (ivc_req[v] && front_head) begin
                            if (!pop) begin
                                state <= router_pkg::ivc_wait_ovc;
                            end else if (!front_tail) begin
                                state <= router_pkg::ivc_active; // granted at once
                            end
                        end
                    end
                    router_pkg::ivc_wait_ovc: begin
                        if (pop) begin
                            state <= front_tail ? router_pkg::ivc_idle : router_pkg::ivc_active;
                        end
                    end
                    router_pkg::ivc_active: begin
                        if (pop && front_tail) begin
                            state <= router_pkg::ivc_idle;
                        end
                    end
                    default: state <= router_pkg::ivc_idle;
                endcase
            end
        end
    end

    // one credit upstream per popped flit
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_out <= '0;
        end else begin
            credit_out <= ivc_grant;
        end
    end

endmodule

// File: vc_sw_alloc.sv
`include "router_defines.svh"

module vc_sw_alloc (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic [`ROUTER_P-1:0][`ROUTER_V-1:0]                  ivc_req,
    input  logic [`ROUTER_P-1:0][`ROUTER_V-1:0][`ROUTER_PW-1:0]  ivc_dest,
    input  logic [`ROUTER_P-1:0][`ROUTER_V-1:0]                  ivc_is_head,
    input  logic [`ROUTER_P-1:0][`ROUTER_V-1:0]                  ivc_is_tail,
    input  logic [`ROUTER_P-1:0][`ROUTER_V-1:0]                  ovc_busy,
    input  logic [`ROUTER_P-1:0][`ROUTER_V-1:0]                  ovc_has_credit,
    input  logic [`ROUTER_P-1:0][`ROUTER_V-1:0][`ROUTER_PW-1:0]  ovc_owner,
    output logic [`ROUTER_P-1:0][`ROUTER_V-1:0]                  ivc_grant,
    output logic [`ROUTER_P-1:0][`ROUTER_V-1:0]                  ovc_alloc,
    output logic [`ROUTER_P-1:0][`ROUTER_V-1:0]                  ovc_release,
    output logic [`ROUTER_P-1:0][`ROUTER_PW-1:0]                 sel_port,
    output logic [`ROUTER_P-1:0]                                 sel_valid
);

    localparam int PV = `ROUTER_P * `ROUTER_V;
    localparam int IW = $clog2(PV);

    logic [`ROUTER_P-1:0][`ROUTER_V-1:0] elig;
    logic [`ROUTER_P-1:0][IW-1:0]        rr_ptr;  // one pointer per output port
    logic [`ROUTER_P-1:0][IW-1:0]        win_idx;

    // the packet keeps its vc, so input vc v asks for output vc v at its dest
    always_comb begin
        logic [`ROUTER_PW-1:0] d;
        for (int p = 0; p < `ROUTER_P; p++) begin
            for (int v = 0; v < `ROUTER_V; v++) begin
                d = ivc_dest[p][v];
                if (ivc_is_head[p][v]) begin
                    elig[p][v] = ivc_req[p][v] && !ovc_busy[d][v] && ovc_has_credit[d][v];
                end else begin
                    elig[p][v] = ivc_req[p][v] && ovc_busy[d][v] &&
                                 (ovc_owner[d][v] == `ROUTER_PW'(p)) && ovc_has_credit[d][v];
                end
            end
        end
    end

    always_comb begin
        logic [`ROUTER_P-1:0] port_taken;
        int idx;
        int ip;
        int iv;
        port_taken  = '0;
        ivc_grant   = '0;
        ovc_alloc   = '0;
        ovc_release = '0;
        sel_valid   = '0;
        sel_port    = '0;
        win_idx     = '0;
        // lowest output port picks first, one grant per input port
        for (int o = 0; o < `ROUTER_P; o++) begin
            for (int k = 0; k < PV; k++) begin
                idx = (int'(rr_ptr[o]) + k) % PV;
                ip  = idx / `ROUTER_V;
                iv  = idx % `ROUTER_V;
                if (!sel_valid[o] && !port_taken[ip] && elig[ip][iv] &&
                    ivc_dest[ip][iv] == `ROUTER_PW'(o)) begin
                    sel_valid[o]      = 1'b1;
                    sel_port[o]       = `ROUTER_PW'(ip);
                    win_idx[o]        = IW'(idx);
                    port_taken[ip]    = 1'b1;
                    ivc_grant[ip][iv] = 1'b1;
                    // single flits neither hold nor free the output vc
                    ovc_alloc[o][iv]   = ivc_is_head[ip][iv] && !ivc_is_tail[ip][iv];
                    ovc_release[o][iv] = ivc_is_tail[ip][iv] && !ivc_is_head[ip][iv];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else begin
            for (int o = 0; o < `ROUTER_P; o++) begin
                if (sel_valid[o]) begin
                    rr_ptr[o] <= (win_idx[o] == IW'(PV - 1)) ? '0 : win_idx[o] + 1'b1;
                end
            end
        end
    end

endmodule

// File: output_port.sv
`include "router_defines.svh"

module output_port (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  sel_valid,   // stage-2 grant
    input  logic [`ROUTER_PW-1:0]                 sel_port,
    input  logic [`ROUTER_VW-1:0]                 sel_vc,
    input  router_pkg::flit_t [`ROUTER_P-1:0]     all_ivc_flits,
    input  logic [`ROUTER_V-1:0]                  ovc_alloc,   // straight from the allocator
    input  logic [`ROUTER_V-1:0]                  ovc_release,
    input  logic [`ROUTER_PW-1:0]                 alloc_owner,
    input  logic [`ROUTER_V-1:0]                  credit_in,
    output router_pkg::flit_t                     flit_out,
    output logic                                  flit_out_wr,
    output logic [`ROUTER_VW-1:0]                 flit_out_vc,
    output logic [`ROUTER_V-1:0]                  ovc_busy,
    output logic [`ROUTER_V-1:0]                  ovc_has_credit,
    output logic [`ROUTER_V-1:0][`ROUTER_PW-1:0]  ovc_owner
);

    for (genvar v = 0; v < `ROUTER_V; v++) begin : g_ovc
        logic [`ROUTER_CW-1:0] credit_cnt;
        logic                  send;

        assign send = sel_valid && (sel_vc == `ROUTER_VW'(v));

        // the flit in stage 2 has not been counted yet
        assign ovc_has_credit[v] = (credit_cnt > `ROUTER_CW'(send));

        always_ff @(posedge clk) begin
            if (rst) begin
                ovc_busy[v] <= 1'b0;
            end else if (ovc_alloc[v]) begin
                ovc_busy[v] <= 1'b1;
            end else if (ovc_release[v]) begin
                ovc_busy[v] <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (ovc_alloc[v]) begin
                ovc_owner[v] <= alloc_owner;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                credit_cnt <= `ROUTER_CW'(`ROUTER_LB);
            end else begin
                credit_cnt <= credit_cnt - `ROUTER_CW'(send) + `ROUTER_CW'(credit_in[v]);
            end
        end
    end

    // crossbar column and link register
    always_ff @(posedge clk) begin
        flit_out    <= all_ivc_flits[sel_port];
        flit_out_vc <= sel_vc;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flit_out_wr <= 1'b0;
        end else begin
            flit_out_wr <= sel_valid;
        end
    end

endmodule

// File: router_two_stage.sv
`include "router_defines.svh"

module router_two_stage (
    input  logic                                  clk,
    input  logic                                  rst,
    input  router_pkg::flit_t [`ROUTER_P-1:0]     flit_in,
    input  logic [`ROUTER_P-1:0]                  flit_in_wr,
    input  logic [`ROUTER_P-1:0][`ROUTER_VW-1:0]  flit_in_vc,
    output logic [`ROUTER_P-1:0][`ROUTER_V-1:0]   credit_out,
    output router_pkg::flit_t [`ROUTER_P-1:0]     flit_out,
    output logic [`ROUTER_P-1:0]                  flit_out_wr,
    output logic [`ROUTER_P-1:0][`ROUTER_VW-1:0]  flit_out_vc,
    input  logic [`ROUTER_P-1:0][`ROUTER_V-1:0]   credit_in
);

    logic [`ROUTER_P-1:0][`ROUTER_V-1:0]                  ivc_req;
    logic [`ROUTER_P-1:0][`ROUTER_V-1:0]                  ivc_is_head;
    logic [`ROUTER_P-1:0][`ROUTER_V-1:0]                  ivc_is_tail;
    logic [`ROUTER_P-1:0][`ROUTER_V-1:0]                  ivc_grant;
    logic [`ROUTER_P-1:0][`ROUTER_V-1:0][`ROUTER_PW-1:0]  ivc_dest;
    router_pkg::flit_t [`ROUTER_P-1:0][`ROUTER_V-1:0]     ivc_flit;
    logic [`ROUTER_P-1:0][`ROUTER_V-1:0]                  ovc_busy;
    logic [`ROUTER_P-1:0][`ROUTER_V-1:0]                  ovc_has_credit;
    logic [`ROUTER_P-1:0][`ROUTER_V-1:0]                  ovc_alloc;
    logic [`ROUTER_P-1:0][`ROUTER_V-1:0]                  ovc_release;
    logic [`ROUTER_P-1:0][`ROUTER_V-1:0][`ROUTER_PW-1:0]  ovc_owner;
    logic [`ROUTER_P-1:0][`ROUTER_PW-1:0]                 sel_port;
    logic [`ROUTER_P-1:0]                                 sel_valid;

    // granted flit and vc per input port, one grant per port at most
    router_pkg::flit_t [`ROUTER_P-1:0]     grant_flit;
    logic [`ROUTER_P-1:0][`ROUTER_VW-1:0]  grant_vc;

    // stage 2
    logic [`ROUTER_P-1:0]                  sel_valid_q;
    logic [`ROUTER_P-1:0][`ROUTER_PW-1:0]  sel_port_q;
    router_pkg::flit_t [`ROUTER_P-1:0]     flit_q;
    logic [`ROUTER_P-1:0][`ROUTER_VW-1:0]  vc_q;

    always_comb begin
        for (int p = 0; p < `ROUTER_P; p++) begin
            grant_vc[p] = '0;
            for (int v = 0; v < `ROUTER_V; v++) begin
                if (ivc_grant[p][v]) grant_vc[p] = `ROUTER_VW'(v);
            end
            grant_flit[p] = ivc_flit[p][grant_vc[p]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_valid_q <= '0;
        end else begin
            sel_valid_q <= sel_valid;
        end
    end

    always_ff @(posedge clk) begin
        sel_port_q <= sel_port;
        flit_q     <= grant_flit;
        vc_q       <= grant_vc;
    end

    for (genvar p = 0; p < `ROUTER_P; p++) begin : g_port
        input_port u_in (
            .clk         (clk),
            .rst         (rst),
            .flit_in     (flit_in[p]),
            .flit_in_wr  (flit_in_wr[p]),
            .flit_in_vc  (flit_in_vc[p]),
            .ivc_grant   (ivc_grant[p]),
            .ivc_req     (ivc_req[p]),
            .ivc_is_head (ivc_is_head[p]),
            .ivc_is_tail (ivc_is_tail[p]),
            .ivc_dest    (ivc_dest[p]),
            .ivc_flit    (ivc_flit[p]),
            .credit_out  (credit_out[p])
        );

        output_port u_out (
            .clk            (clk),
            .rst            (rst),
            .sel_valid      (sel_valid_q[p]),
            .sel_port       (sel_port_q[p]),
            .sel_vc         (vc_q[sel_port_q[p]]), // vc of the winning input port
            .all_ivc_flits  (flit_q),
            .ovc_alloc      (ovc_alloc[p]),
            .ovc_release    (ovc_release[p]),
            .alloc_owner    (sel_port[p]),
            .credit_in      (credit_in[p]),
            .flit_out       (flit_out[p]),
            .flit_out_wr    (flit_out_wr[p]),
            .flit_out_vc    (flit_out_vc[p]),
            .ovc_busy       (ovc_busy[p]),
            .ovc_has_credit (ovc_has_credit[p]),
            .ovc_owner      (ovc_owner[p])
        );
    end

    vc_sw_alloc u_alloc (
        .clk            (clk),
        .rst            (rst),
        .ivc_req        (ivc_req),
        .ivc_dest       (ivc_dest),
        .ivc_is_head    (ivc_is_head),
        .ivc_is_tail    (ivc_is_tail),
        .ovc_busy       (ovc_busy),
        .ovc_has_credit (ovc_has_credit),
        .ovc_owner      (ovc_owner),
        .ivc_grant      (ivc_grant),
        .ovc_alloc      (ovc_alloc),
        .ovc_release    (ovc_release),
        .sel_port       (sel_port),
        .sel_valid      (sel_valid)
    );

endmodule

// File: router_assertions.sv
`include "router_defines.svh"

module router_assertions (
    input logic                                  clk,
    input logic                                  rst,
    input logic [`ROUTER_P-1:0]                  flit_in_wr,
    input logic [`ROUTER_P-1:0]                  flit_out_wr,
    input logic [`ROUTER_P-1:0][`ROUTER_VW-1:0]  flit_out_vc,
    input logic [`ROUTER_P-1:0][`ROUTER_V-1:0]   credit_in,
    input logic [`ROUTER_P-1:0][`ROUTER_V-1:0]   credit_out
);

    logic [`ROUTER_P-1:0][`ROUTER_V-1:0][3:0] unreturned; // flits sent minus credits back
    logic over_limit;
    logic credit_multi;
    logic traffic_seen; // set by the first flit written after reset

    always_ff @(posedge clk) begin
        if (rst) begin
            unreturned <= '0;
        end else begin
            for (int o = 0; o < `ROUTER_P; o++) begin
                for (int v = 0; v < `ROUTER_V; v++) begin
                    unreturned[o][v] <= unreturned[o][v]
                        + 4'(flit_out_wr[o] && (flit_out_vc[o] == `ROUTER_VW'(v)))
                        - 4'(credit_in[o][v]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            traffic_seen <= 1'b0;
        end else if (flit_in_wr != '0) begin
            traffic_seen <= 1'b1;
        end
    end

    always_comb begin
        over_limit   = 1'b0;
        credit_multi = 1'b0;
        for (int o = 0; o < `ROUTER_P; o++) begin
            for (int v = 0; v < `ROUTER_V; v++) begin
                if (unreturned[o][v] > 4'(`ROUTER_LB)) over_limit = 1'b1;
            end
            if (!$onehot0(credit_out[o])) credit_multi = 1'b1; // one pop per input port
        end
    end

    a_credit_limit: assert property (@(posedge clk) disable iff (rst) !over_limit)
        else $error("output vc holds more unreturned flits than buffer slots");

    a_credit_onehot: assert property (@(posedge clk) disable iff (rst) !credit_multi)
        else $error("more than one credit_out pulse on an input port in one cycle");

    a_quiet_until_traffic: assert property (@(posedge clk) disable iff (rst)
        !traffic_seen |-> (flit_out_wr == '0 && credit_out == '0))
        else $error("flit_out_wr or credit_out active before any flit was written");

endmodule

// File: router_tb.sv
`include "router_defines.svh"

module router_tb;

    localparam int N_PKT     = 10; // packets per input vc per traffic test
    localparam int SEQ_W     = `ROUTER_DW - `ROUTER_PW - `ROUTER_VW;
    localparam int PKT_TOTAL = 2 * N_PKT * `ROUTER_P * `ROUTER_V + 1;
    localparam int WD_CYCLES = PKT_TOTAL * 4 * 40;

    logic                                  clk;
    logic                                  rst;
    router_pkg::flit_t [`ROUTER_P-1:0]     flit_in;
    logic [`ROUTER_P-1:0]                  flit_in_wr;
    logic [`ROUTER_P-1:0][`ROUTER_VW-1:0]  flit_in_vc;
    logic [`ROUTER_P-1:0][`ROUTER_V-1:0]   credit_in;
    logic [`ROUTER_P-1:0][`ROUTER_V-1:0]   credit_out;
    router_pkg::flit_t [`ROUTER_P-1:0]     flit_out;
    logic [`ROUTER_P-1:0]                  flit_out_wr;
    logic [`ROUTER_P-1:0][`ROUTER_VW-1:0]  flit_out_vc;

    // everything below is indexed [port][vc]
    router_pkg::flit_t send_q [`ROUTER_P][`ROUTER_V][$]; // upstream, not yet written
    router_pkg::flit_t exp_q  [`ROUTER_P][`ROUTER_V][$]; // model, by source
    int up_cred   [`ROUTER_P][`ROUTER_V];
    int sent      [`ROUTER_P][`ROUTER_V];
    int cred_seen [`ROUTER_P][`ROUTER_V];
    int seq       [`ROUTER_P][`ROUTER_V];
    int pend      [`ROUTER_P][`ROUTER_V]; // unreturned flits per output vc
    int hold      [`ROUTER_P][`ROUTER_V]; // downstream stall cycles left
    int cur_src   [`ROUTER_P][`ROUTER_V];
    bit in_pkt    [`ROUTER_P][`ROUTER_V];

    int seed;
    int errors;
    int checks;
    int rx_total;
    int test_err0;

    router_two_stage dut_i (
        .clk         (clk),
        .rst         (rst),
        .flit_in     (flit_in),
        .flit_in_wr  (flit_in_wr),
        .flit_in_vc  (flit_in_vc),
        .credit_out  (credit_out),
        .flit_out    (flit_out),
        .flit_out_wr (flit_out_wr),
        .flit_out_vc (flit_out_vc),
        .credit_in   (credit_in)
    );

    bind router_two_stage router_assertions u_assert (
        .clk         (clk),
        .rst         (rst),
        .flit_in_wr  (flit_in_wr),
        .flit_out_wr (flit_out_wr),
        .flit_out_vc (flit_out_vc),
        .credit_in   (credit_in),
        .credit_out  (credit_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int rand_below(int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    task automatic check_flit(string what, router_pkg::flit_t got, router_pkg::flit_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_port(string what, router_pkg::port_t got, router_pkg::port_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_count(string what, int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_error(string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // payload = source port, vc, sequence number
    task automatic add_packet(int p, int v, int len, int dest);
        router_pkg::flit_t f;
        for (int i = 0; i < len; i++) begin
            if (len == 1) f.ftype = router_pkg::flit_single;
            else if (i == 0) f.ftype = router_pkg::flit_head;
            else if (i == len - 1) f.ftype = router_pkg::flit_tail;
            else f.ftype = router_pkg::flit_body;
            f.dest_port = router_pkg::port_t'(dest);
            f.payload   = {`ROUTER_PW'(p), `ROUTER_VW'(v), SEQ_W'(seq[p][v])};
            seq[p][v]++;
            send_q[p][v].push_back(f);
            exp_q[p][v].push_back(f);
        end
    endtask

    task automatic build_traffic();
        int len;
        int dest;
        for (int p = 0; p < `ROUTER_P; p++) begin
            for (int v = 0; v < `ROUTER_V; v++) begin
                for (int k = 0; k < N_PKT; k++) begin
                    len  = 1 + rand_below(4);
                    dest = rand_below(`ROUTER_P);
                    add_packet(p, v, len, dest);
                end
            end
        end
    endtask

    task automatic handle_rx(int o);
        router_pkg::flit_t f;
        router_pkg::flit_t exp;
        int v;
        int src;
        f = flit_out[o];
        v = int'(flit_out_vc[o]);
        rx_total++;
        pend[o][v]++;
        if (pend[o][v] > `ROUTER_LB)
            report_error($sformatf("port %0d vc %0d got more flits than credits", o, v));
        if (!in_pkt[o][v] && (f.ftype == router_pkg::flit_body ||
                              f.ftype == router_pkg::flit_tail)) begin
            report_error($sformatf("port %0d vc %0d got a flit outside a packet", o, v));
            return;
        end
        // the head names the source, the rest of the packet follows it
        src = in_pkt[o][v] ? cur_src[o][v] : int'(f.payload[`ROUTER_DW-1 -: `ROUTER_PW]);
        if (exp_q[src][v].size() == 0) begin
            report_error($sformatf("port %0d vc %0d got a flit nobody sent", o, v));
            return;
        end
        exp = exp_q[src][v].pop_front();
        check_flit($sformatf("flit on port %0d vc %0d", o, v), f, exp);
        check_port($sformatf("out port of src %0d vc %0d", src, v), router_pkg::port_t'(o),
                   exp.dest_port);
        cur_src[o][v] = src;
        in_pkt[o][v]  = (f.ftype == router_pkg::flit_head) || (f.ftype == router_pkg::flit_body);
    endtask

    task automatic sample_outputs();
        for (int o = 0; o < `ROUTER_P; o++) begin
            if (flit_out_wr[o]) handle_rx(o);
        end
        for (int p = 0; p < `ROUTER_P; p++) begin
            for (int v = 0; v < `ROUTER_V; v++) begin
                if (credit_out[p][v]) begin
                    cred_seen[p][v]++;
                    up_cred[p][v]++;
                end
            end
        end
    endtask

    // downstream side, one credit per cycle per vc, with random holds
    task automatic drive_credits(bit stall);
        credit_in = '0;
        for (int o = 0; o < `ROUTER_P; o++) begin
            for (int v = 0; v < `ROUTER_V; v++) begin
                if (hold[o][v] > 0) begin
                    hold[o][v]--;
                end else if (pend[o][v] > 0) begin
                    credit_in[o][v] = 1'b1;
                    pend[o][v]--;
                    if (stall && rand_below(6) == 0) hold[o][v] = 1 + rand_below(16);
                end
            end
        end
    endtask

    task automatic drive_flits(int idle_pct);
        int start;
        int vv;
        int pick;
        flit_in_wr = '0;
        for (int p = 0; p < `ROUTER_P; p++) begin
            start = rand_below(`ROUTER_V);
            pick  = -1;
            for (int k = 0; k < `ROUTER_V; k++) begin
                vv = (start + k) % `ROUTER_V;
                if (pick < 0 && send_q[p][vv].size() > 0 && up_cred[p][vv] > 0) pick = vv;
            end
            if (pick >= 0 && rand_below(100) >= idle_pct) begin
                flit_in[p]    = send_q[p][pick].pop_front();
                flit_in_vc[p] = `ROUTER_VW'(pick);
                flit_in_wr[p] = 1'b1;
                up_cred[p][pick]--;
                sent[p][pick]++;
            end
        end
    endtask

    task automatic step(int idle_pct, bit stall);
        @(negedge clk);
        sample_outputs(); // outputs are stable here
        drive_credits(stall);
        drive_flits(idle_pct);
    endtask

    function automatic bit all_drained();
        for (int p = 0; p < `ROUTER_P; p++) begin
            for (int v = 0; v < `ROUTER_V; v++) begin
                if (send_q[p][v].size() != 0 || exp_q[p][v].size() != 0 ||
                    pend[p][v] != 0 || up_cred[p][v] != `ROUTER_LB) return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic end_test(string name);
        if (errors == test_err0) $display("test %s: pass", name);
        else $display("test %s: fail, %0d errors", name, errors - test_err0);
        test_err0 = errors;
    endtask

    task automatic run_traffic(string name, bit stall);
        build_traffic();
        while (!all_drained()) step(25, stall);
        end_test(name);
    endtask

    initial begin
        int rx0;
        int lat;
        seed      = 62;
        errors    = 0;
        checks    = 0;
        rx_total  = 0;
        test_err0 = 0;
        rst        = 1'b1;
        flit_in    = '0;
        flit_in_wr = '0;
        flit_in_vc = '0;
        credit_in  = '0;
        for (int p = 0; p < `ROUTER_P; p++) begin
            for (int v = 0; v < `ROUTER_V; v++) begin
                up_cred[p][v]   = `ROUTER_LB;
                sent[p][v]      = 0;
                cred_seen[p][v] = 0;
                seq[p][v]       = 0;
                pend[p][v]      = 0;
                hold[p][v]      = 0;
                cur_src[p][v]   = 0;
                in_pkt[p][v]    = 1'b0;
            end
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (5) begin
            step(0, 1'b0);
            check_count("flit_out_wr after reset", int'(flit_out_wr), 0);
            check_count("credit_out after reset", int'(credit_out), 0);
        end
        end_test("idle_after_reset");

        // lone single flit, port 0 vc 0 to port 2
        add_packet(0, 0, 1, 2);
        rx0 = rx_total;
        step(0, 1'b0);
        lat = 0;
        while (rx_total == rx0 && lat < 20) begin
            step(0, 1'b0);
            lat++;
        end
        check_count("lone flit latency in cycles", lat, 3);
        while (!all_drained()) step(0, 1'b0);
        end_test("lone_flit_latency");

        run_traffic("random_traffic", 1'b0);
        run_traffic("backpressure_stalls", 1'b1);

        repeat (4) step(0, 1'b0);
        for (int p = 0; p < `ROUTER_P; p++) begin
            for (int v = 0; v < `ROUTER_V; v++) begin
                check_count($sformatf("credit_out pulses port %0d vc %0d", p, v),
                            cred_seen[p][v], sent[p][v]);
                check_count($sformatf("upstream credits port %0d vc %0d", p, v),
                            up_cred[p][v], `ROUTER_LB);
            end
        end
        end_test("credit_accounting");

        $display("tests done, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // bound from the packet count, 4 flits each, 40 cycles per flit
    initial begin
        #(WD_CYCLES * 8);
        $display("ERROR: watchdog expired after %0d cycles, traffic did not drain", WD_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: sources.f
+incdir+.
router_pkg.sv
input_port.sv
vc_sw_alloc.sv
output_port.sv
router_two_stage.sv
router_assertions.sv
router_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= router_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Done: errors found
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG) || \
	   ! grep -q "$(PASS_MSG)" $(LOG); then \
	    echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
